// File: filelist.f
+incdir+.
cpu_pkg.sv
instrDecoder.sv
controlFsm.sv
regFile.sv
aluUnit.sv
busMaster.sv
cpuTop.sv
cpu_properties.sv
cpuChecker.sv
cpuTb.sv

// File: cpuTb.sv
`include "cpu_settings.svh"

module cpuTb
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROG_LEN = 200;
	localparam int MAX_WAIT = 3;
	localparam int RESET_CYCLES = 16;

	integer seed = 32'hfa92_75b4;

	logic clk = 1'b0;
	logic rst = 1'b0;
	wbRsp_t wbRsp = '0;
	wbReq_t wbReq;
	logic finished;
	int errorCount;

	// Slave memory and its wait-state counter
	word_t mem [word_t];
	logic pending = 1'b0;
	int waitLeft = 0;

	always #20 clk = ~clk;

	cpuTop dut0 (
		.clk   (clk),
		.rst   (rst),
		.wbRsp (wbRsp),
		.wbReq (wbReq)
	);

	cpuChecker #(
		.PROG_LEN (PROG_LEN)
	) check0 (
		.clk        (clk),
		.rst        (rst),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.finished   (finished),
		.errorCount (errorCount)
	);

	////////////////////////////// Program

	// ALU opcodes, the first six also serve as register-form extensions
	function automatic logic [3:0] aluCode(int k);
		case (k)
			0:       return OP_ANDI;
			1:       return OP_ORI;
			2:       return OP_XORI;
			3:       return OP_ADDI;
			4:       return OP_SUBI;
			5:       return OP_MOVI;
			default: return OP_LUI;
		endcase
	endfunction

	// Untouched memory, a different word at every address
	function automatic word_t fillWord(word_t a);
		return {a[7:0], a[15:8]} ^ 16'hc3a5;
	endfunction

	task automatic drawInstr(input int idx, output word_t ins);
		int kind;
		regIdx_t rd;
		regIdx_t rs;
		logic [7:0] imm;
		kind = $unsigned($random(seed)) % 16;
		rd = regIdx_t'($random(seed));
		rs = regIdx_t'($random(seed));
		imm = 8'($random(seed));
		if (idx < `CPU_REG_N) begin
			// Upper byte nonzero, so early data addresses sit above the program
			ins = {OP_LUI, regIdx_t'(idx), imm | 8'h10};
		end else if (kind < 4) begin
			ins = {OP_MEM, rd, 4'h4, rs};
		end else if (kind < 7) begin
			ins = {OP_MEM, rd, 4'h0, rs};
		end else if (kind < 12) begin
			ins = {aluCode($unsigned($random(seed)) % 7), rd, imm};
		end else begin
			ins = {OP_REG, rd, aluCode($unsigned($random(seed)) % 6), rs};
		end
	endtask

	////////////////////////////// Memory slave

	always @(posedge clk) begin
		if (!rst) begin
			wbRsp <= '0;
			pending = 1'b0;
		end else if (wbRsp.ack) begin
			wbRsp.ack <= 1'b0;
		end else if (wbReq.cyc && wbReq.stb) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = $unsigned($random(seed)) % (MAX_WAIT + 1);
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				if (wbReq.we) begin
					mem[wbReq.adr] = wbReq.dat;
				end
				wbRsp <= '{ack: 1'b1, dat: mem[wbReq.adr]};
			end else begin
				waitLeft--;
			end
		end
	end

	////////////////////////////// Run

	initial begin
		word_t w;
		for (int a = 0; a < 65536; a++) begin
			if (a < PROG_LEN) begin
				drawInstr(a, w);
			end else begin
				w = fillWord(word_t'(a));
			end
			mem[word_t'(a)] = w;
			check0.preload(word_t'(a), w);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		// Checker raises finished on completion or at its cycle limit
		wait (finished === 1'b1);
		if (dut0.props0.violations != 0) begin
			$display("protocol assertions failed %0d times", dut0.props0.violations);
		end
		if (errorCount == 0 && dut0.props0.violations == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: cpuChecker.sv
`include "cpu_settings.svh"

module cpuChecker
	import cpu_pkg::*;
#(
	parameter int PROG_LEN = 200
) (
	input  logic   clk,
	input  logic   rst,
	input  wbReq_t wbReq,
	input  wbRsp_t wbRsp,
	output logic   finished,
	output int     errorCount
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = PROG_LEN * 14 + 100;
	localparam int N_TESTS = 6;
	localparam int T_FETCH = 0;
	localparam int T_ALU = 1;
	localparam int T_STORE = 2;
	localparam int T_LOAD = 3;
	localparam int T_BACKP = 4;
	localparam int T_DONE = 5;

	// Model state
	word_t mem [word_t];
	word_t regs [`CPU_REG_N];
	logic loaded [`CPU_REG_N];
	word_t pc;
	int fetchCount;
	int cycles;
	logic expectData;
	logic pendIsStore;
	regIdx_t pendRd;
	word_t pendAddr;
	logic inAccess;
	wbReq_t heldReq;
	int checks [N_TESTS];
	int errs [N_TESTS];

	function automatic string testName(int t);
		case (t)
			T_FETCH: return "fetch order";
			T_ALU:   return "alu results";
			T_STORE: return "store access";
			T_LOAD:  return "load path";
			T_BACKP: return "back-pressure";
			default: return "completion";
		endcase
	endfunction

	// Codes 1,2,3,5,9,d are ALU ops in both forms, f (LUI) only as immediate
	function automatic logic aluCodeOk(logic [3:0] code, logic regForm);
		case (code)
			4'h1, 4'h2, 4'h3, 4'h5, 4'h9, 4'hd: return 1'b1;
			4'hf:    return !regForm;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t aluModel(logic [3:0] code, word_t a, word_t b);
		case (code)
			4'h1:    return a & b;
			4'h2:    return a | b;
			4'h3:    return a ^ b;
			4'h5:    return a + b;
			4'h9:    return a - b;
			4'hd:    return b;
			4'hf:    return {b[7:0], 8'h00};
			default: return a;
		endcase
	endfunction

	task automatic preload(input word_t addr, input word_t data);
		mem[addr] = data;
	endtask

	task automatic compareWord(input int test, input string sigName, input word_t expVal,
		input word_t actVal);
		checks[test]++;
		if (actVal !== expVal) begin
			errs[test]++;
			$display("ERROR t=%0t %s expected %h got %h", $time, sigName, expVal, actVal);
		end
	endtask

	task automatic reportTests();
		int failed;
		int total;
		failed = 0;
		total = 0;
		for (int i = 0; i < N_TESTS; i++) begin
			total += errs[i];
			if (checks[i] == 0 || errs[i] != 0) begin
				failed++;
			end
			$display("%s: %0d checks, %0d errors, %s", testName(i), checks[i], errs[i],
				(checks[i] != 0 && errs[i] == 0) ? "ok" : "FAIL");
		end
		$display("tests: %0d ok, %0d failing, %0d errors in all", N_TESTS - failed, failed, total);
		errorCount = failed;
		finished = 1'b1;
	endtask

	//////////////////////////////
	// Instruction-set model
	//////////////////////////////

	task automatic executeInstr(input word_t ins);
		logic [3:0] opc;
		logic [3:0] ext;
		regIdx_t rd;
		regIdx_t rs;
		word_t b;
		opc = ins[15:12];
		rd = ins[11:8];
		ext = ins[7:4];
		rs = ins[3:0];
		if (opc == 4'h4) begin
			// LOAD is ext 0, STOR is ext 4
			if (ext == 4'h0 || ext == 4'h4) begin
				expectData = 1'b1;
				pendIsStore = (ext == 4'h4);
				pendRd = rd;
				pendAddr = regs[rs];
			end
		end else if (opc == 4'h0) begin
			if (aluCodeOk(ext, 1'b1)) begin
				regs[rd] = aluModel(ext, regs[rd], regs[rs]);
				loaded[rd] = 1'b0;
			end
		end else if (aluCodeOk(opc, 1'b0)) begin
			// Sign extension only for ADD and SUB
			if (opc == 4'h5 || opc == 4'h9) begin
				b = {{8{ins[7]}}, ins[7:0]};
			end else begin
				b = {8'h00, ins[7:0]};
			end
			regs[rd] = aluModel(opc, regs[rd], b);
			loaded[rd] = 1'b0;
		end
	endtask

	task automatic handleAccess();
		int test;
		if (!expectData) begin
			compareWord(T_FETCH, "wbReq.adr", pc, wbReq.adr);
			compareWord(T_BACKP, "wbReq.we", '0, word_t'(wbReq.we));
			fetchCount++;
			if (fetchCount > PROG_LEN) begin
				checks[T_DONE]++;
				reportTests();
			end else begin
				executeInstr(mem[pc]);
				pc = pc + word_t'(1);
			end
		end else begin
			test = pendIsStore ? T_STORE : T_LOAD;
			compareWord(test, "wbReq.adr", pendAddr, wbReq.adr);
			compareWord(test, "wbReq.we", word_t'(pendIsStore), word_t'(wbReq.we));
			if (pendIsStore) begin
				test = loaded[pendRd] ? T_LOAD : T_ALU;
				compareWord(test, "wbReq.dat", regs[pendRd], wbReq.dat);
				mem[pendAddr] = regs[pendRd];
			end else begin
				regs[pendRd] = mem[pendAddr];
				loaded[pendRd] = 1'b1;
			end
			expectData = 1'b0;
		end
	endtask

	//////////////////////////////
	// Bus monitor
	//////////////////////////////

	always @(posedge clk) begin
		if (!rst) begin
			pc = '0;
			fetchCount = 0;
			cycles = 0;
			expectData = 1'b0;
			inAccess = 1'b0;
			finished = 1'b0;
			errorCount = 0;
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] = '0;
				loaded[i] = 1'b0;
			end
		end else if (!finished) begin
			cycles++;
			if (wbReq.stb) begin
				if (!inAccess) begin
					heldReq = wbReq;
					inAccess = 1'b1;
				end else begin
					compareWord(T_BACKP, "wbReq.adr", heldReq.adr, wbReq.adr);
					compareWord(T_BACKP, "wbReq.dat", heldReq.dat, wbReq.dat);
					compareWord(T_BACKP, "wbReq.we", word_t'(heldReq.we), word_t'(wbReq.we));
				end
				if (wbRsp.ack) begin
					inAccess = 1'b0;
					handleAccess();
				end
			end
			if (!finished && cycles >= CYCLE_LIMIT) begin
				$display("timeout: program did not complete");
				checks[T_DONE]++;
				errs[T_DONE]++;
				reportTests();
			end
		end
	end

endmodule

// File: cpu_properties.sv
module cpuProperties
	import cpu_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input wbReq_t     wbReq,
	input wbRsp_t     wbRsp,
	input ctrlState_t fsmState
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far
	int violations = 0;

	// Both strobes fall in the cycle after the ack
	dropAfterAck: assert property (@(posedge clk) disable iff (!rst)
		wbReq.stb && wbRsp.ack |=> !wbReq.cyc && !wbReq.stb)
	else begin
		$error("cyc or stb still high after ack");
		violations++;
	end

	// Request held steady until the slave acks
	holdUntilAck: assert property (@(posedge clk) disable iff (!rst)
		wbReq.stb && !wbRsp.ack |=> wbReq.stb && $stable(wbReq.adr)
			&& $stable(wbReq.dat) && $stable(wbReq.we))
	else begin
		$error("request changed or dropped before ack");
		violations++;
	end

	// Bus idle and FSM in FETCH once reset has been seen
	resetValues: assert property (@(posedge clk)
		!rst |=> !wbReq.cyc && !wbReq.stb && !wbReq.we && fsmState == FETCH)
	else begin
		$error("wrong bus or FSM state after reset");
		violations++;
	end

endmodule

bind cpuTop cpuProperties props0 (
	.clk      (clk),
	.rst      (rst),
	.wbReq    (wbReq),
	.wbRsp    (wbRsp),
	.fsmState (fsmState)
);

// File: cpuTop.sv
module cpuTop
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  wbRsp_t wbRsp,
	output wbReq_t wbReq
);

	ctrlSig_t ctrl;
	decoded_t dec;
	logic busDone;
	word_t instr;
	word_t rdata;
	word_t rdataA;
	word_t rdataB;
	word_t aluB;
	word_t aluResult;
	word_t wbData;

	// Current FSM state, kept visible at the top for bound checks
	ctrlState_t fsmState;

	//////////////////////////////
	// Datapath muxes
	//////////////////////////////

	assign aluB = dec.useImm ? dec.imm : rdataB;
	assign wbData = ctrl.wbSelMem ? rdata : aluResult;

	//////////////////////////////
	// Core blocks
	//////////////////////////////

	controlFsm fsm0 (
		.clk     (clk),
		.rst     (rst),
		.dec     (dec),
		.busDone (busDone),
		.ctrl    (ctrl),
		.state   (fsmState)
	);

	instrDecoder decoder0 (
		.instr (instr),
		.dec   (dec)
	);

	regFile regs0 (
		.clk    (clk),
		.rst    (rst),
		.we     (ctrl.regWe),
		.raddrA (dec.rd),
		.raddrB (dec.rs),
		.waddr  (dec.rd),
		.wdata  (wbData),
		.rdataA (rdataA),
		.rdataB (rdataB)
	);

	aluUnit alu0 (
		.op     (dec.aluOp),
		.a      (rdataA),
		.b      (aluB),
		.result (aluResult)
	);

	// Address from rs, store data from rd
	busMaster bus0 (
		.clk   (clk),
		.rst   (rst),
		.ctrl  (ctrl),
		.addr  (rdataB),
		.wdata (rdataA),
		.wbRsp (wbRsp),
		.wbReq (wbReq),
		.instr (instr),
		.rdata (rdata),
		.done  (busDone)
	);

endmodule

// File: busMaster.sv
module busMaster
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  ctrlSig_t ctrl,
	input  word_t    addr,
	input  word_t    wdata,
	input  wbRsp_t   wbRsp,
	output wbReq_t   wbReq,
	output word_t    instr,
	output word_t    rdata,
	output logic     done
);

	word_t pc;
	logic active;
	logic we;
	word_t adr;
	word_t dat;
	logic start;

	// Open a cycle only from idle, so one idle cycle always follows an ack
	assign start = ctrl.busReq & ~active;
	assign done = active & wbRsp.ack;

	// cyc and stb move together for single classic accesses
	assign wbReq = '{cyc: active, stb: active, we: we, adr: adr, dat: dat};

	always_ff @(posedge clk) begin
		if (!rst) begin
			active <= 1'b0;
			we <= 1'b0;
		end else if (done) begin
			active <= 1'b0;
			we <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
			we <= ctrl.busWe;
		end
	end

	// Held for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			adr <= ctrl.busData ? addr : pc;
			dat <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= '0;
		end else if (done && ctrl.pcInc) begin
			pc <= pc + word_t'(1);
		end
	end

	// Fetch word or load data, taken on the ack edge
	always_ff @(posedge clk) begin
		if (done && ctrl.irLoad) begin
			instr <= wbRsp.dat;
		end
		if (done && ctrl.busData && !ctrl.busWe) begin
			rdata <= wbRsp.dat;
		end
	end

endmodule

// File: aluUnit.sv
`include "cpu_settings.svh"

module aluUnit
	import cpu_pkg::*;
(
	input  aluOp_t op,
	input  word_t  a,
	input  word_t  b,
	output word_t  result
);

	localparam int HALF_W = `CPU_DATA_W / 2;

	word_t upperImm;

	// Immediate byte moved up, low byte cleared
	assign upperImm = {b[HALF_W-1:0], {HALF_W{1'b0}}};

	always_comb begin
		case (op)
			ADD: begin
				result = a + b;
			end
			SUB: begin
				result = a - b;
			end
			AND: begin
				result = a & b;
			end
			OR: begin
				result = a | b;
			end
			XOR: begin
				result = a ^ b;
			end
			// Operand a is ignored for moves
			MOV: begin
				result = b;
			end
			LUI: begin
				result = upperImm;
			end
			default: begin
				result = b;
			end
		endcase
	end

endmodule

// File: regFile.sv
`include "cpu_settings.svh"

module regFile
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    we,
	input  regIdx_t raddrA,
	input  regIdx_t raddrB,
	input  regIdx_t waddr,
	input  word_t   wdata,
	output word_t   rdataA,
	output word_t   rdataB
);

	word_t regs [`CPU_REG_N];

	// Single write port
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads
	// A is rd / store data, B is rs / address
	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

endmodule

// File: controlFsm.sv
module controlFsm
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  decoded_t   dec,
	input  logic       busDone,
	output ctrlSig_t   ctrl,
	output ctrlState_t state
);

	ctrlState_t nextState;
	logic isMem;

	assign isMem = dec.isLoad | dec.isStore;

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			// Wait on the bus for the instruction word
			FETCH: begin
				if (busDone) begin
					nextState = DECODE;
				end
			end
			DECODE: begin
				nextState = EXEC;
			end
			// ALU ops retire here
			EXEC: begin
				if (isMem) begin
					nextState = MEM;
				end else begin
					nextState = FETCH;
				end
			end
			MEM: begin
				if (busDone) begin
					nextState = dec.isLoad ? WBACK : FETCH;
				end
			end
			WBACK: begin
				nextState = FETCH;
			end
			default: begin
				nextState = FETCH;
			end
		endcase
	end

	//////////////////////////////
	// Control outputs
	//////////////////////////////

	always_comb begin
		// Everything idle unless the state asks for it
		ctrl = '0;
		case (state)
			FETCH: begin
				ctrl.busReq = 1'b1;
				ctrl.irLoad = 1'b1;
				ctrl.pcInc = 1'b1;
			end
			DECODE: ;
			// Loads write back later, from the bus
			EXEC: begin
				ctrl.regWe = dec.writesReg & ~dec.isLoad;
			end
			MEM: begin
				ctrl.busReq = 1'b1;
				ctrl.busData = 1'b1;
				ctrl.busWe = dec.isStore;
			end
			WBACK: begin
				ctrl.regWe = dec.writesReg;
				ctrl.wbSelMem = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: instrDecoder.sv
module instrDecoder
	import cpu_pkg::*;
(
	input  word_t    instr,
	output decoded_t dec
);

	// Extension codes under OP_MEM
	localparam logic [3:0] EXT_LOAD = 4'h0;
	localparam logic [3:0] EXT_STOR = 4'h4;

	opcode_t opc;
	opcode_t aluCode;
	logic [3:0] ext;
	word_t immZero;
	word_t immSign;

	assign opc = opcode_t'(instr[15:12]);
	assign ext = instr[7:4];
	assign immZero = {8'h00, instr[7:0]};
	assign immSign = {{8{instr[7]}}, instr[7:0]};

	// Register forms carry the operation in the extension nibble
	assign aluCode = (opc == OP_REG) ? opcode_t'(ext) : opc;

	always_comb begin
		dec = '0;
		dec.rd = instr[11:8];
		dec.rs = instr[3:0];
		dec.aluOp = MOV;
		dec.imm = immZero;
		dec.useImm = (opc != OP_REG);

		case (aluCode)
			OP_ADDI: begin
				dec.aluOp = ADD;
				dec.imm = immSign;
				dec.writesReg = 1'b1;
			end
			OP_SUBI: begin
				dec.aluOp = SUB;
				dec.imm = immSign;
				dec.writesReg = 1'b1;
			end
			OP_ANDI: begin
				dec.aluOp = AND;
				dec.writesReg = 1'b1;
			end
			OP_ORI: begin
				dec.aluOp = OR;
				dec.writesReg = 1'b1;
			end
			OP_XORI: begin
				dec.aluOp = XOR;
				dec.writesReg = 1'b1;
			end
			// MOVI keeps the zero-extended byte
			OP_MOVI: begin
				dec.aluOp = MOV;
				dec.writesReg = 1'b1;
			end
			// No register form of LUI
			OP_LUI: begin
				dec.aluOp = LUI;
				dec.writesReg = (opc == OP_LUI);
			end
			default: ;
		endcase

		// LOAD rdest, raddr and STOR rsrc, raddr
		if (opc == OP_MEM) begin
			dec.useImm = 1'b0;
			if (ext == EXT_LOAD) begin
				dec.isLoad = 1'b1;
				dec.writesReg = 1'b1;
			end else if (ext == EXT_STOR) begin
				dec.isStore = 1'b1;
			end
		end
	end

endmodule

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_REG_IDX_W-1:0] regIdx_t;

	// Primary opcodes in bits 15:12
	// Register forms reuse the same numbers in the extension field
	typedef enum logic [3:0] {
		OP_REG  = 4'h0,
		OP_ANDI = 4'h1,
		OP_ORI  = 4'h2,
		OP_XORI = 4'h3,
		OP_MEM  = 4'h4,
		OP_ADDI = 4'h5,
		OP_SUBI = 4'h9,
		OP_MOVI = 4'hd,
		OP_LUI  = 4'hf
	} opcode_t;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, MOV, LUI} aluOp_t;

	typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WBACK} ctrlState_t;

	typedef struct packed {
		aluOp_t  aluOp;
		regIdx_t rd;
		regIdx_t rs;
		logic    useImm;
		word_t   imm;
		logic    isLoad;
		logic    isStore;
		logic    writesReg;
	} decoded_t;

	typedef struct packed {
		logic regWe;
		logic wbSelMem;
		logic irLoad;
		logic pcInc;
		logic busReq;
		logic busWe;
		logic busData;
	} ctrlSig_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wbReq_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wbRsp_t;

endpackage

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

//////////////////////////////
// Core widths
//////////////////////////////

// Data, address and instruction width
`define CPU_DATA_W 16

// Size of the register file
`define CPU_REG_N 16

// Bits needed to name one register
`define CPU_REG_IDX_W 4

// Memory is word addressed, so the PC steps by one per instruction
// and a full address fits in one register

`endif
